// ==== vlog.f ====
rtl/isa_pkg.sv
rtl/uarch_pkg.sv
rtl/reservation_station.sv
rtl/issue_ctrl.sv
rtl/alu_unit.sv
rtl/mult_unit.sv
rtl/ooo_issue_top.sv
sim/tb_ooo_issue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ooo_issue
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_ooo_issue.sv ====
`timescale 1ns/10ps

module tb_ooo_issue;

    localparam int NUM_ENTRIES     = 8;
    localparam int MULT_RADIX_BITS = 2;
    localparam int NUM_TAGS        = 16;
    // closest legal spacing of two multiplier results
    localparam int MUL_GAP         = 32 / 2 + 1;
    // about 40 instructions, each worst case a full multiply, plus margin
    localparam int TIMEOUT         = 4000;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         load;
    isa_pkg::opcode_t             load_op;
    logic [3:0]                   load_tag;
    logic                         load_src1_ready, load_src2_ready;
    logic [3:0]                   load_src1_tag, load_src2_tag;
    logic [31:0]                  load_src1_value, load_src2_value;
    logic [1:0]                   wakeup_valid;
    logic [1:0][3:0]              wakeup_tag;
    logic [1:0][31:0]             wakeup_value;
    logic                         is_full;

    // scoreboard, indexed by tag
    int                           disp_cnt [NUM_TAGS];
    int                           done_cnt [NUM_TAGS];
    int                           done_cyc [NUM_TAGS];
    // producer tag and the dispatch count it has to reach
    int                           dep1 [NUM_TAGS];
    int                           dep2 [NUM_TAGS];
    int                           need1 [NUM_TAGS];
    int                           need2 [NUM_TAGS];
    logic                         is_mul [NUM_TAGS];
    logic [31:0]                  exp_val [NUM_TAGS];
    int                           cycle = 0;
    int                           last_mul = -1000;
    int                           full_cycles = 0;
    int                           err_assert = 0;
    int                           err_final = 0;
    int                           tests = 0;
    logic [31:0]                  lfsr_state = 32'h4265;

    ooo_issue_top #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .MULT_RADIX_BITS(MULT_RADIX_BITS)
    ) UUT (
        .clk, .reset, .load, .load_op, .load_tag,
        .load_src1_ready, .load_src1_tag, .load_src1_value,
        .load_src2_ready, .load_src2_tag, .load_src2_value,
        .wakeup_valid, .wakeup_tag, .wakeup_value, .is_full
    );

    always #4 clk = ~clk;

    // expected result straight from the opcode definitions
    function automatic logic [31:0] ref_result(isa_pkg::opcode_t op, logic [31:0] a,
                                               logic [31:0] b);
        case (op)
            isa_pkg::OP_ADD: return a + b;
            isa_pkg::OP_SUB: return a - b;
            isa_pkg::OP_AND: return a & b;
            isa_pkg::OP_OR:  return a | b;
            isa_pkg::OP_XOR: return a ^ b;
            isa_pkg::OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::OP_MUL: return a * b;
            default:         return 32'd0;
        endcase
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic tag_busy(int t);
        return disp_cnt[t] != done_cnt[t];
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic random_op(output isa_pkg::opcode_t op);
        logic [31:0] r;
        take_bits(3, r);
        op = (r[2:0] == 3'd7) ? isa_pkg::OP_ADD : isa_pkg::opcode_t'(r[2:0]);
    endtask

    // one load, sources ready unless the producer is still out
    task automatic dispatch(input isa_pkg::opcode_t op, input int d1, input int d2,
                            output int tag);
        logic [31:0] a, b;
        logic        r1, r2;
        tag = -1;
        while (tag < 0) begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                if (tag < 0 && !tag_busy(i)) begin
                    tag = i;
                end
            end
            if (tag < 0) begin
                @(posedge clk);
                #1;
            end
        end
        take_bits(32, a);
        take_bits(32, b);
        // back-pressure
        while (is_full) begin
            @(posedge clk);
            #1;
        end
        r1 = (d1 < 0) || !tag_busy(d1);
        r2 = (d2 < 0) || !tag_busy(d2);
        if (d1 >= 0) begin
            a = exp_val[d1];
        end
        if (d2 >= 0) begin
            b = exp_val[d2];
        end
        exp_val[tag]    = ref_result(op, a, b);
        dep1[tag]       = (d1 < 0) ? 0 : d1;
        dep2[tag]       = (d2 < 0) ? 0 : d2;
        need1[tag]      = (d1 < 0) ? 0 : disp_cnt[d1];
        need2[tag]      = (d2 < 0) ? 0 : disp_cnt[d2];
        is_mul[tag]     = (op == isa_pkg::OP_MUL);
        disp_cnt[tag]   = disp_cnt[tag] + 1;
        load            = 1'b1;
        load_op         = op;
        load_tag        = 4'(tag);
        load_src1_ready = r1;
        load_src1_tag   = (d1 < 0) ? 4'd0 : 4'(d1);
        load_src1_value = r1 ? a : 32'd0;
        load_src2_ready = r2;
        load_src2_tag   = (d2 < 0) ? 4'd0 : 4'(d2);
        load_src2_value = r2 ? b : 32'd0;
        @(posedge clk);
        #1;
        load = 1'b0;
    endtask

    task automatic drain();
        logic any;
        any = 1'b1;
        while (any) begin
            any = 1'b0;
            for (int i = 0; i < NUM_TAGS; i++) begin
                any = any | tag_busy(i);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_test(input string name);
        tests = tests + 1;
        $display("test %0d %s finished, %0d errors so far", tests, name,
                 err_assert + err_final);
    endtask

    // result bookkeeping and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!reset) begin
            for (int w = 0; w < 2; w++) begin
                if (wakeup_valid[w]) begin
                    done_cnt[wakeup_tag[w]] <= done_cnt[wakeup_tag[w]] + 1;
                    done_cyc[wakeup_tag[w]] <= cycle;
                end
            end
            if (wakeup_valid[1]) begin
                last_mul <= cycle;
            end
            if (is_full) begin
                full_cycles <= full_cycles + 1;
            end
        end
        if (cycle >= TIMEOUT) begin
            $display("timeout after %0d cycles, results still outstanding", cycle);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // quiet outputs during reset and the cycle after
    a_reset_quiet: assert property (@(posedge clk)
        ((reset || $past(reset)) && cycle >= 2) |-> (wakeup_valid == 2'b00 && !is_full))
        else begin
            err_assert++;
            $display("error %0t wakeup_valid/is_full got %b/%b expected 00/0", $time,
                     $sampled(wakeup_valid), $sampled(is_full));
        end

    a_mul_spacing: assert property (@(posedge clk) disable iff (reset)
        wakeup_valid[1] |-> (cycle - last_mul >= MUL_GAP))
        else begin
            err_assert++;
            $display("multiplier results at %0t closer than %0d cycles", $time, MUL_GAP);
        end

    for (genvar w = 0; w < 2; w++) begin : g_port
        // each result belongs to an instruction in flight, once
        a_tag_in_flight: assert property (@(posedge clk) disable iff (reset)
            wakeup_valid[w] |-> disp_cnt[wakeup_tag[w]] > done_cnt[wakeup_tag[w]])
            else begin
                err_assert++;
                $display("port %0d at %0t broadcast tag %0d that was not in flight", w,
                         $time, $sampled(wakeup_tag[w]));
            end

        a_value: assert property (@(posedge clk) disable iff (reset)
            wakeup_valid[w] |-> wakeup_value[w] == exp_val[wakeup_tag[w]])
            else begin
                err_assert++;
                $display("error %0t wakeup_value[%0d] got %h expected %h", $time, w,
                         $sampled(wakeup_value[w]), exp_val[$sampled(wakeup_tag[w])]);
            end

        // port 0 is the ALU only, port 1 the multiplier only
        a_unit_kind: assert property (@(posedge clk) disable iff (reset)
            wakeup_valid[w] |-> is_mul[wakeup_tag[w]] == (w == 1))
            else begin
                err_assert++;
                $display("port %0d at %0t carried a result of the wrong unit", w, $time);
            end

        a_producers_first: assert property (@(posedge clk) disable iff (reset)
            wakeup_valid[w] |-> (done_cnt[dep1[wakeup_tag[w]]] >= need1[wakeup_tag[w]] &&
                                 done_cnt[dep2[wakeup_tag[w]]] >= need2[wakeup_tag[w]]))
            else begin
                err_assert++;
                $display("port %0d at %0t gave a result before its producers", w, $time);
            end
    end

    initial begin
        int               t, prev, ma, mb, c;
        isa_pkg::opcode_t op;
        for (int i = 0; i < NUM_TAGS; i++) begin
            disp_cnt[i] = 0;
            dep1[i]     = 0;
            dep2[i]     = 0;
            need1[i]    = 0;
            need2[i]    = 0;
            is_mul[i]   = 1'b0;
            exp_val[i]  = '0;
        end
        reset = 1'b1;
        load = 1'b0;
        load_op = isa_pkg::OP_ADD;
        load_tag = '0;
        load_src1_ready = 1'b0;
        load_src1_tag = '0;
        load_src1_value = '0;
        load_src2_ready = 1'b0;
        load_src2_tag = '0;
        load_src2_value = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        end_test("reset");

        // every ALU opcode plus two multiplies, all operands ready
        for (int k = 0; k < 6; k++) begin
            dispatch(isa_pkg::opcode_t'(k), -1, -1, t);
        end
        dispatch(isa_pkg::OP_MUL, -1, -1, t);
        dispatch(isa_pkg::OP_MUL, -1, -1, t);
        drain();
        end_test("ready operands");

        // chains through random opcodes, multiplies included
        for (int ch = 0; ch < 3; ch++) begin
            dispatch(isa_pkg::OP_MUL, -1, -1, prev);
            for (int k = 0; k < 5; k++) begin
                random_op(op);
                dispatch(op, prev, (k == 2) ? prev : -1, t);
                prev = t;
            end
        end
        drain();
        end_test("dependency chains");

        // independent ALU op passes a multiply held behind a busy unit
        dispatch(isa_pkg::OP_MUL, -1, -1, ma);
        dispatch(isa_pkg::OP_MUL, -1, -1, mb);
        dispatch(isa_pkg::OP_XOR, -1, -1, c);
        drain();
        assert (done_cyc[c] < done_cyc[mb]) else begin
            err_final++;
            $display("ALU op did not overtake the waiting multiply");
        end
        end_test("ALU overtakes multiply");

        // station fills behind one outstanding multiply
        dispatch(isa_pkg::OP_MUL, -1, -1, ma);
        for (int k = 0; k <= NUM_ENTRIES; k++) begin
            random_op(op);
            if (op == isa_pkg::OP_MUL) begin
                op = isa_pkg::OP_SUB;
            end
            dispatch(op, ma, -1, t);
        end
        drain();
        assert (full_cycles > 0) else begin
            err_final++;
            $display("is_full never rose with the station filled");
        end
        end_test("back-pressure");

        repeat (MUL_GAP) @(posedge clk);
        #1;
        for (int i = 0; i < NUM_TAGS; i++) begin
            assert (disp_cnt[i] == done_cnt[i]) else begin
                err_final++;
                $display("tag %0d dispatched %0d times but completed %0d times", i,
                         disp_cnt[i], done_cnt[i]);
            end
        end
        end_test("completeness");

        $display("tests %0d, errors %0d", tests, err_assert + err_final);
        if (err_assert + err_final == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/ooo_issue_top.sv ====
`timescale 1ns/10ps

module ooo_issue_top #(
    parameter int NUM_ENTRIES     = 8,
    parameter int MULT_RADIX_BITS = 2
) (
    input  logic                                                     clk,
    input  logic                                                     reset,
    // dispatch side
    input  logic                                                     load,
    input  isa_pkg::opcode_t                                         load_op,
    input  logic [uarch_pkg::TAG_LEN-1:0]                            load_tag,
    input  logic                                                     load_src1_ready,
    input  logic [uarch_pkg::TAG_LEN-1:0]                            load_src1_tag,
    input  logic [isa_pkg::XLEN-1:0]                                 load_src1_value,
    input  logic                                                     load_src2_ready,
    input  logic [uarch_pkg::TAG_LEN-1:0]                            load_src2_tag,
    input  logic [isa_pkg::XLEN-1:0]                                 load_src2_value,
    // result broadcast, also fed back to the station
    output logic [uarch_pkg::NUM_WAKEUP-1:0]                         wakeup_valid,
    output logic [uarch_pkg::NUM_WAKEUP-1:0][uarch_pkg::TAG_LEN-1:0] wakeup_tag,
    output logic [uarch_pkg::NUM_WAKEUP-1:0][isa_pkg::XLEN-1:0]      wakeup_value,
    output logic                                                     is_full
);

    // station to control and units
    logic                          sel_valid;
    isa_pkg::opcode_t              sel_op;
    logic [uarch_pkg::TAG_LEN-1:0] sel_tag;
    logic [isa_pkg::XLEN-1:0]      sel_src1_value, sel_src2_value;
    // control outputs
    logic                          issue, alu_start, mult_start, mult_block;
    // unit results
    logic                          mult_done;
    logic                          alu_valid, mul_valid;
    logic [uarch_pkg::TAG_LEN-1:0] alu_tag, mul_tag;
    logic [isa_pkg::XLEN-1:0]      alu_value, mul_value;

    // port 1 multiplier, port 0 ALU
    assign wakeup_valid = {mul_valid, alu_valid};
    assign wakeup_tag   = {mul_tag, alu_tag};
    assign wakeup_value = {mul_value, alu_value};

    reservation_station #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_rs (
        .clk, .reset, .load, .load_op, .load_tag,
        .load_src1_ready, .load_src1_tag, .load_src1_value,
        .load_src2_ready, .load_src2_tag, .load_src2_value,
        .wakeup_valid, .wakeup_tag, .wakeup_value,
        .mult_block, .issue,
        .sel_valid, .sel_op, .sel_tag, .sel_src1_value, .sel_src2_value,
        .is_full
    );

    issue_ctrl u_ctrl (
        .clk, .reset, .sel_valid, .sel_op, .mult_done,
        .issue, .alu_start, .mult_start, .mult_block
    );

    alu_unit u_alu (
        .clk, .reset, .start(alu_start), .op(sel_op), .tag(sel_tag),
        .src1(sel_src1_value), .src2(sel_src2_value),
        .result_valid(alu_valid), .result_tag(alu_tag), .result_value(alu_value)
    );

    mult_unit #(
        .MULT_RADIX_BITS(MULT_RADIX_BITS)
    ) u_mult (
        .clk, .reset, .start(mult_start), .tag(sel_tag),
        .src1(sel_src1_value), .src2(sel_src2_value), .done(mult_done),
        .result_valid(mul_valid), .result_tag(mul_tag), .result_value(mul_value)
    );

endmodule

// ==== rtl/mult_unit.sv ====
`timescale 1ns/10ps

module mult_unit #(
    parameter int MULT_RADIX_BITS = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic [uarch_pkg::TAG_LEN-1:0] tag,
    input  logic [isa_pkg::XLEN-1:0]      src1,
    input  logic [isa_pkg::XLEN-1:0]      src2,
    output logic                          done,
    // wakeup port 1
    output logic                          result_valid,
    output logic [uarch_pkg::TAG_LEN-1:0] result_tag,
    output logic [isa_pkg::XLEN-1:0]      result_value
);

    localparam int ITERS = isa_pkg::XLEN / MULT_RADIX_BITS;
    localparam int CNT_W = (ITERS > 1) ? $clog2(ITERS) : 1;

    logic                     running;
    logic                     last;
    logic [CNT_W-1:0]         count;
    logic [isa_pkg::XLEN-1:0] mcand, mplier, partial;

    assign last = (count == CNT_W'(ITERS - 1));

    // shifted multiplicand for the current digit
    always_comb begin
        partial = '0;
        for (int b = 0; b < MULT_RADIX_BITS; b++) begin
            if (mplier[b]) begin
                partial = partial + (mcand << b);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running      <= 1'b0;
            count        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= running && last;
            if (start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (last) begin
                    running <= 1'b0;
                end
            end
        end
    end

    // accumulator doubles as the result register, low half only
    always_ff @(posedge clk) begin
        if (start) begin
            mcand        <= src1;
            mplier       <= src2;
            result_value <= '0;
            result_tag   <= tag;
        end else if (running) begin
            result_value <= result_value + partial;
            mcand        <= mcand << MULT_RADIX_BITS;
            mplier       <= mplier >> MULT_RADIX_BITS;
        end
    end

    // done marks the same cycle as the broadcast
    assign done = result_valid;

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  isa_pkg::opcode_t              op,
    input  logic [uarch_pkg::TAG_LEN-1:0] tag,
    input  logic [isa_pkg::XLEN-1:0]      src1,
    input  logic [isa_pkg::XLEN-1:0]      src2,
    // wakeup port 0
    output logic                          result_valid,
    output logic [uarch_pkg::TAG_LEN-1:0] result_tag,
    output logic [isa_pkg::XLEN-1:0]      result_value
);

    // one-cycle pulse per start
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= start;
        end
    end

    // result and tag captured with the start
    always_ff @(posedge clk) begin
        if (start) begin
            result_tag   <= tag;
            result_value <= isa_pkg::alu_eval(op, src1, src2);
        end
    end

    // control must route multiplies elsewhere
    a_no_mul_on_alu: assert property (@(posedge clk) disable iff (reset)
        start |-> op != isa_pkg::OP_MUL);

endmodule

// ==== rtl/issue_ctrl.sv ====
`timescale 1ns/10ps

module issue_ctrl (
    input  logic             clk,
    input  logic             reset,
    // from the station
    input  logic             sel_valid,
    input  isa_pkg::opcode_t sel_op,
    // from the multiplier
    input  logic             mult_done,
    output logic             issue,
    output logic             alu_start,
    output logic             mult_start,
    output logic             mult_block
);

    uarch_pkg::mult_state_t state, state_next;
    logic                   sel_is_mul;

    assign sel_is_mul = (uarch_pkg::unit_t'(isa_pkg::unit_of(sel_op)) == uarch_pkg::UNIT_MUL);

    // one grant per cycle, whenever something is issuable
    assign issue      = sel_valid;
    assign alu_start  = sel_valid && !sel_is_mul;
    assign mult_start = sel_valid && sel_is_mul;

    // released in the done cycle so a waiting multiply can go right away
    assign mult_block = (state == uarch_pkg::MULT_BUSY) && !mult_done;

    always_comb begin
        state_next = state;
        case (state)
            uarch_pkg::MULT_IDLE: begin
                if (mult_start) begin
                    state_next = uarch_pkg::MULT_BUSY;
                end
            end
            uarch_pkg::MULT_BUSY: begin
                // back-to-back start keeps the unit busy
                if (mult_done && !mult_start) begin
                    state_next = uarch_pkg::MULT_IDLE;
                end
            end
            default: state_next = uarch_pkg::MULT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= uarch_pkg::MULT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // station must hold multiplies back while the unit is occupied
    a_no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
        (state == uarch_pkg::MULT_BUSY && !mult_done) |-> !mult_start);

    // a result only comes back for a multiply that was started
    a_done_only_when_busy: assert property (@(posedge clk) disable iff (reset)
        mult_done |-> state == uarch_pkg::MULT_BUSY);

endmodule

// ==== rtl/reservation_station.sv ====
`timescale 1ns/10ps

module reservation_station #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                                                   clk,
    input  logic                                                   reset,
    // dispatch side
    input  logic                                                   load,
    input  isa_pkg::opcode_t                                       load_op,
    input  logic [uarch_pkg::TAG_LEN-1:0]                          load_tag,
    input  logic                                                   load_src1_ready,
    input  logic [uarch_pkg::TAG_LEN-1:0]                          load_src1_tag,
    input  logic [isa_pkg::XLEN-1:0]                               load_src1_value,
    input  logic                                                   load_src2_ready,
    input  logic [uarch_pkg::TAG_LEN-1:0]                          load_src2_tag,
    input  logic [isa_pkg::XLEN-1:0]                               load_src2_value,
    // result broadcast from both units
    input  logic [uarch_pkg::NUM_WAKEUP-1:0]                       wakeup_valid,
    input  logic [uarch_pkg::NUM_WAKEUP-1:0][uarch_pkg::TAG_LEN-1:0] wakeup_tag,
    input  logic [uarch_pkg::NUM_WAKEUP-1:0][isa_pkg::XLEN-1:0]    wakeup_value,
    // from issue control
    input  logic                                                   mult_block,
    input  logic                                                   issue,
    // selected entry
    output logic                                                   sel_valid,
    output isa_pkg::opcode_t                                       sel_op,
    output logic [uarch_pkg::TAG_LEN-1:0]                          sel_tag,
    output logic [isa_pkg::XLEN-1:0]                               sel_src1_value,
    output logic [isa_pkg::XLEN-1:0]                               sel_src2_value,
    output logic                                                   is_full
);

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    // entries in age order, index 0 oldest
    logic [NUM_ENTRIES-1:0]            ent_valid, ent_s1_rdy, ent_s2_rdy;
    isa_pkg::opcode_t                  ent_op     [NUM_ENTRIES];
    logic [uarch_pkg::TAG_LEN-1:0]     ent_tag    [NUM_ENTRIES];
    logic [uarch_pkg::TAG_LEN-1:0]     ent_s1_tag [NUM_ENTRIES];
    logic [uarch_pkg::TAG_LEN-1:0]     ent_s2_tag [NUM_ENTRIES];
    logic [isa_pkg::XLEN-1:0]          ent_s1_val [NUM_ENTRIES];
    logic [isa_pkg::XLEN-1:0]          ent_s2_val [NUM_ENTRIES];

    logic [NUM_ENTRIES-1:0]            n_valid, n_s1_rdy, n_s2_rdy;
    isa_pkg::opcode_t                  n_op       [NUM_ENTRIES];
    logic [uarch_pkg::TAG_LEN-1:0]     n_tag      [NUM_ENTRIES];
    logic [uarch_pkg::TAG_LEN-1:0]     n_s1_tag   [NUM_ENTRIES];
    logic [uarch_pkg::TAG_LEN-1:0]     n_s2_tag   [NUM_ENTRIES];
    logic [isa_pkg::XLEN-1:0]          n_s1_val   [NUM_ENTRIES];
    logic [isa_pkg::XLEN-1:0]          n_s2_val   [NUM_ENTRIES];

    logic [IDX_W-1:0] sel_idx;

    // oldest entry with both sources ready
    // multiplies are passed over while the multiplier is occupied
    always_comb begin
        sel_valid = 1'b0;
        sel_idx = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!sel_valid && ent_valid[i] && ent_s1_rdy[i] && ent_s2_rdy[i] &&
                !(mult_block && uarch_pkg::unit_t'(isa_pkg::unit_of(ent_op[i])) ==
                  uarch_pkg::UNIT_MUL)) begin
                sel_valid = 1'b1;
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign sel_op         = ent_op[sel_idx];
    assign sel_tag        = ent_tag[sel_idx];
    assign sel_src1_value = ent_s1_val[sel_idx];
    assign sel_src2_value = ent_s2_val[sel_idx];

    // queue stays compacted, so full means the top slot is taken
    assign is_full = &ent_valid;

    always_comb begin
        int  src;
        logic placed;
        placed   = 1'b0;
        n_valid  = ent_valid;
        n_s1_rdy = ent_s1_rdy;
        n_s2_rdy = ent_s2_rdy;
        n_op     = ent_op;
        n_tag    = ent_tag;
        n_s1_tag = ent_s1_tag;
        n_s2_tag = ent_s2_tag;
        n_s1_val = ent_s1_val;
        n_s2_val = ent_s2_val;
        // drop the issued entry, younger ones slide down one slot
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            src = (issue && i >= int'(sel_idx)) ? i + 1 : i;
            if (src < NUM_ENTRIES) begin
                n_valid[i]  = ent_valid[src];
                n_s1_rdy[i] = ent_s1_rdy[src];
                n_s2_rdy[i] = ent_s2_rdy[src];
                n_op[i]     = ent_op[src];
                n_tag[i]    = ent_tag[src];
                n_s1_tag[i] = ent_s1_tag[src];
                n_s2_tag[i] = ent_s2_tag[src];
                n_s1_val[i] = ent_s1_val[src];
                n_s2_val[i] = ent_s2_val[src];
            end else begin
                n_valid[i] = 1'b0;
            end
        end
        // new instruction goes into the first free slot
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (load && !placed && !n_valid[i]) begin
                placed      = 1'b1;
                n_valid[i]  = 1'b1;
                n_op[i]     = load_op;
                n_tag[i]    = load_tag;
                n_s1_rdy[i] = load_src1_ready;
                n_s1_tag[i] = load_src1_tag;
                n_s1_val[i] = load_src1_value;
                n_s2_rdy[i] = load_src2_ready;
                n_s2_tag[i] = load_src2_tag;
                n_s2_val[i] = load_src2_value;
            end
        end
        // tag match on every port, incoming entry included
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            for (int w = 0; w < uarch_pkg::NUM_WAKEUP; w++) begin
                if (wakeup_valid[w] && !n_s1_rdy[i] && n_s1_tag[i] == wakeup_tag[w]) begin
                    n_s1_rdy[i] = 1'b1;
                    n_s1_val[i] = wakeup_value[w];
                end
                if (wakeup_valid[w] && !n_s2_rdy[i] && n_s2_tag[i] == wakeup_tag[w]) begin
                    n_s2_rdy[i] = 1'b1;
                    n_s2_val[i] = wakeup_value[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_valid <= '0;
        end else begin
            ent_valid <= n_valid;
        end
    end

    // entry payload, qualified by ent_valid
    always_ff @(posedge clk) begin
        ent_s1_rdy <= n_s1_rdy;
        ent_s2_rdy <= n_s2_rdy;
        ent_op     <= n_op;
        ent_tag    <= n_tag;
        ent_s1_tag <= n_s1_tag;
        ent_s2_tag <= n_s2_tag;
        ent_s1_val <= n_s1_val;
        ent_s2_val <= n_s2_val;
    end

    // dispatcher must honour back-pressure
    a_no_load_when_full: assert property (@(posedge clk) disable iff (reset)
        load |-> !is_full);

    // control grants only what the station offers
    a_issue_needs_sel: assert property (@(posedge clk) disable iff (reset)
        issue |-> sel_valid);

endmodule

// ==== rtl/uarch_pkg.sv ====
package uarch_pkg;

    // producer tag width, 16 tags in flight
    localparam int TAG_LEN = 4;

    // broadcast ports
    // port 0 carries the ALU, port 1 the multiplier
    localparam int NUM_WAKEUP = 2;

    // execution unit kind
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_t;

    // multiplier occupancy, tracked by issue control
    typedef enum logic {
        MULT_IDLE = 1'b0,
        MULT_BUSY = 1'b1
    } mult_state_t;

endpackage

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    // integer datapath width
    localparam int XLEN = 32;

    // integer opcodes seen by the issue stage
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        // signed compare, result is 0 or 1
        OP_SLT = 3'd5,
        OP_MUL = 3'd6
    } opcode_t;

    // unit kind, 1 means the multiplier
    function automatic logic unit_of(opcode_t op);
        return (op == OP_MUL);
    endfunction

    // single-cycle opcode rules
    function automatic logic [XLEN-1:0] alu_eval(opcode_t op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            // multiply is handled by its own unit
            default: return '0;
        endcase
    endfunction

endpackage
